/* Bender.yml */
package:
  name: wb_pipe

sources:
  - isa_pkg.sv
  - pipe_pkg.sv
  - line_fill_apb.sv
  - mem_access_stage.sv
  - writeback_stage.sv
  - wb_pipe_top.sv
  - target: test
    files:
      - wb_pipe_props.sv
      - tb_wb_pipe.sv

/* isa_pkg.sv */
// Vector ISA definitions
// Load opcodes, register numbers and lane geometry
`default_nettype none

package isa_pkg;

	// Lane geometry
	localparam int NUM_LANES = 16;
	localparam int LANE_W = 32;
	localparam int VEC_W = NUM_LANES * LANE_W;
	localparam int LANE_IDX_W = 4;
	localparam int BYTE_W = 8;

	// Register numbering
	localparam int REG_IDX_W = 5;
	localparam logic [REG_IDX_W-1:0] PC_REG = 5'd31;

	// Operation classes seen at the back of the pipeline
	typedef enum logic [2:0]
	{
		OP_ARITH,
		OP_LD_UBYTE,
		OP_LD_SBYTE,
		OP_LD_UHALF,
		OP_LD_SHALF,
		OP_LD_WORD,
		OP_LD_BLOCK,
		OP_LD_GATHER
	} load_op_e;

	// Loads that return one 32-bit value
	function automatic logic is_scalar_load(input load_op_e op);
		return op == OP_LD_UBYTE || op == OP_LD_SBYTE || op == OP_LD_UHALF
			|| op == OP_LD_SHALF || op == OP_LD_WORD;
	endfunction

endpackage

`default_nettype wire

/* line_fill_apb.sv */
// Line store with APB fill port
`timescale 1ns/10ps
`default_nettype none

module line_fill_apb
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic psel_i,
	input wire logic penable_i,
	input wire logic pwrite_i,
	input wire logic [APB_ADDR_W-1:0] paddr_i,
	input wire logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	input wire logic [LINE_IDX_W-1:0] rd_line_i,
	output logic [VEC_W-1:0] rd_data_o,
	output logic rd_valid_o
);

	logic [VEC_W-1:0] lines [LINE_COUNT];
	logic [LINE_COUNT-1:0] line_valid;

	logic [31:0] addr_ext;
	logic [LINE_IDX_W-1:0] apb_line;
	logic [LANE_IDX_W-1:0] apb_lane;
	logic access;
	logic in_store;
	logic is_inval;

	assign addr_ext = {{(32 - APB_ADDR_W){1'b0}}, paddr_i};
	assign apb_line = addr_line(addr_ext);
	assign apb_lane = addr_lane(addr_ext);

	// Access phase of a transfer, never extended
	assign access = psel_i && penable_i;
	assign in_store = paddr_i < INVAL_ADDR;
	assign is_inval = pwrite_i && paddr_i == INVAL_ADDR;

	assign pready_o = 1'b1;
	assign pslverr_o = access && !in_store && !is_inval;
	assign prdata_o = lines[apb_line][apb_lane * LANE_W +: LANE_W];

	always_ff @(posedge clk)
	begin
		if (access && pwrite_i && in_store)
			lines[apb_line][apb_lane * LANE_W +: LANE_W] <= pwdata_i;
	end

	// Any word write marks its line present
	always_ff @(posedge clk)
	begin
		if (reset_i)
			line_valid <= '0;
		else if (access && is_inval)
			line_valid <= '0;
		else if (access && pwrite_i && in_store)
			line_valid[apb_line] <= 1'b1;
	end

	// Pipeline read port sees state before this edge's write
	assign rd_data_o = lines[rd_line_i];
	assign rd_valid_o = line_valid[rd_line_i];

endmodule

`default_nettype wire

/* list.f */
isa_pkg.sv
pipe_pkg.sv
line_fill_apb.sv
mem_access_stage.sv
writeback_stage.sv
wb_pipe_top.sv
wb_pipe_props.sv
tb_wb_pipe.sv

/* mem_access_stage.sv */
// Memory access stage
// Line store lookup and stage register
`timescale 1ns/10ps
`default_nettype none

module mem_access_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset_i,
	input wire issue_t issue_i,
	input wire logic [VEC_W-1:0] result_vec_i,
	input wire logic flush_i,
	output logic [LINE_IDX_W-1:0] rd_line_o,
	input wire logic [VEC_W-1:0] rd_data_i,
	input wire logic rd_valid_i,
	output mem_rsp_t rsp_o,
	output logic [VEC_W-1:0] rsp_vec_o
);

	logic valid_q;
	issue_t issue_q;
	logic [VEC_W-1:0] line_q;
	logic hit_q;
	logic [VEC_W-1:0] vec_q;

	// Effective address selects the line
	assign rd_line_o = addr_line(issue_i.result);

	// Valid bit is control state, cleared by reset and by a rollback
	always_ff @(posedge clk)
	begin
		if (reset_i)
			valid_q <= 1'b0;
		else
			valid_q <= issue_i.valid && !flush_i;
	end

	always_ff @(posedge clk)
	begin
		issue_q <= issue_i;
		line_q <= rd_data_i;
		hit_q <= rd_valid_i;
		vec_q <= result_vec_i;
	end

	always_comb
	begin
		rsp_o.inst = issue_q;
		rsp_o.inst.valid = valid_q;
		rsp_o.line = line_q;
		rsp_o.hit = hit_q;
	end

	assign rsp_vec_o = vec_q;

endmodule

`default_nettype wire

/* pipe_pkg.sv */
// Pipeline payloads
// Stage structs and line store geometry
`default_nettype none

package pipe_pkg;
	import isa_pkg::*;

	// Line store geometry
	localparam int LINE_COUNT = 16;
	localparam int LINE_IDX_W = 4;
	localparam int APB_ADDR_W = 12;
	localparam logic [APB_ADDR_W-1:0] INVAL_ADDR = 12'h400;

	// Address layout: line in 9:6, lane in 5:2, byte offset in 1:0
	localparam int LINE_LSB = 6;
	localparam int LANE_LSB = 2;
	localparam int BYTE_OFS_W = 2;

	typedef struct packed {
		logic valid;
		load_op_e op;
		logic [31:0] pc;
		logic [REG_IDX_W-1:0] dest_reg;
		logic is_vector;
		logic has_writeback;
		logic [NUM_LANES-1:0] mask;
		logic [LANE_IDX_W-1:0] reg_lane;
		logic [LANE_W-1:0] result;
	} issue_t;

	typedef struct packed {
		issue_t inst;
		logic [VEC_W-1:0] line;
		logic hit;
	} mem_rsp_t;

	typedef struct packed {
		logic valid;
		logic is_vector;
		logic [REG_IDX_W-1:0] dest_reg;
		logic [VEC_W-1:0] value;
		logic [NUM_LANES-1:0] mask;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic [31:0] addr;
	} rollback_t;

	function automatic logic [LINE_IDX_W-1:0] addr_line(input logic [31:0] addr);
		return addr[LINE_LSB +: LINE_IDX_W];
	endfunction

	function automatic logic [LANE_IDX_W-1:0] addr_lane(input logic [31:0] addr);
		return addr[LANE_LSB +: LANE_IDX_W];
	endfunction

	function automatic logic [BYTE_OFS_W-1:0] addr_ofs(input logic [31:0] addr);
		return addr[BYTE_OFS_W-1:0];
	endfunction

endpackage

`default_nettype wire

/* tb_wb_pipe.sv */
// Memory access and writeback pipeline testbench
`timescale 1ns/10ps
`default_nettype none

module tb_wb_pipe
	import isa_pkg::*;
	import pipe_pkg::*;
();

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 8;
	localparam int FILL_WORDS = LINE_COUNT * NUM_LANES;
	localparam int ERR_ACCESSES = 8;
	localparam int READ_CHECKS = 48;
	localparam int REFILL_WORDS = 2 * NUM_LANES;
	localparam int SCALAR_LOADS = 60;
	localparam int VEC_LOADS = 40;
	localparam int ARITH_OPS = 30;
	localparam int MISS_OPS = 48;
	localparam int PC_OPS = 24;
	// Three clocks per APB transfer, one per issued instruction
	localparam int APB_CYCLES = 3 * (FILL_WORDS + 2 * ERR_ACCESSES + READ_CHECKS
		+ REFILL_WORDS + 1);
	localparam int PIPE_CYCLES = SCALAR_LOADS + VEC_LOADS + ARITH_OPS + MISS_OPS
		+ PC_OPS + 6 * 4;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + APB_CYCLES + PIPE_CYCLES + 200;

	typedef struct packed {
		logic [31:0] cyc;
		logic wb_valid;
		logic is_vector;
		logic [REG_IDX_W-1:0] dest_reg;
		logic [VEC_W-1:0] value;
		logic [NUM_LANES-1:0] mask;
		logic rb_valid;
		logic [31:0] rb_addr;
	} expect_t;

	logic clk;
	logic reset_i;
	issue_t issue;
	logic [VEC_W-1:0] result_vec;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_ADDR_W-1:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	wb_t wb;
	rollback_t rollback;

	// Reference copy of the line store
	logic [VEC_W-1:0] m_lines [LINE_COUNT];
	logic [LINE_COUNT-1:0] m_valid = '0;

	expect_t pend [$];
	integer seed;
	int cycle = 0;
	int last_rb_cyc = -100;
	int errors = 0;
	int checks = 0;
	int test_errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int prop_failures = 0;
	string test_name = "reset";

	wb_pipe_top UUT (
		.clk(clk),
		.reset_i(reset_i),
		.issue_i(issue),
		.result_vec_i(result_vec),
		.psel_i(psel),
		.penable_i(penable),
		.pwrite_i(pwrite),
		.paddr_i(paddr),
		.pwdata_i(pwdata),
		.prdata_o(prdata),
		.pready_o(pready),
		.pslverr_o(pslverr),
		.wb_o(wb),
		.rollback_o(rollback)
	);

	bind wb_pipe_top wb_pipe_props u_props (
		.clk(clk),
		.reset_i(reset_i),
		.rb_valid_i(rollback_o.valid),
		.wb_valid_i(wb_o.valid),
		.pready_i(pready_o)
	);

	initial
		clk = 1'b0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [VEC_W-1:0] rand_vec();
		logic [VEC_W-1:0] v;
		for (int i = 0; i < NUM_LANES; i++)
			v[i * LANE_W +: LANE_W] = rand_word();
		return v;
	endfunction

	function automatic issue_t make_inst(input load_op_e op, input logic [31:0] addr,
		input logic [REG_IDX_W-1:0] dest);
		issue_t inst;
		inst = '0;
		inst.valid = 1'b1;
		inst.op = op;
		inst.pc = rand_word() & 32'hFFFF_FFFC;
		inst.dest_reg = dest;
		inst.is_vector = op == OP_LD_BLOCK || op == OP_LD_GATHER || op == OP_ARITH;
		inst.has_writeback = 1'b1;
		inst.mask = 16'(rand_word());
		inst.reg_lane = 4'(rand_word());
		inst.result = addr;
		return inst;
	endfunction

	task automatic check_value(input string what, input logic [VEC_W-1:0] exp_v,
		input logic [VEC_W-1:0] act_v);
		checks++;
		assert (act_v === exp_v)
		else
		begin
			errors++;
			$display("Error %s, %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
		end
	endtask

	// Drive one instruction and predict what leaves the pipe two clocks later
	task automatic drive_inst(input issue_t inst, input logic [VEC_W-1:0] vec);
		expect_t e;
		logic [VEC_W-1:0] line;
		logic [LANE_W-1:0] word;
		logic [LANE_W-1:0] ext;
		logic [7:0] byte_v;
		logic [15:0] half_v;
		logic [1:0] ofs;
		logic live;
		logic miss;
		logic pc_load;
		@(posedge clk);
		issue <= inst;
		result_vec <= vec;
		line = m_lines[inst.result[9:6]];
		word = line[inst.result[5:2] * LANE_W +: LANE_W];
		ofs = inst.result[1:0];
		// Big-endian, offset 0 is the top byte
		byte_v = 8'(word >> (8 * (3 - ofs)));
		half_v = ofs[1] ? word[15:0] : word[31:16];
		case (inst.op)
			OP_LD_UBYTE: ext = {24'h0, byte_v};
			OP_LD_SBYTE: ext = {{24{byte_v[7]}}, byte_v};
			OP_LD_UHALF: ext = {16'h0, half_v};
			OP_LD_SHALF: ext = {{16{half_v[15]}}, half_v};
			default: ext = word;
		endcase
		e = '0;
		e.cyc = cycle;
		e.is_vector = inst.is_vector;
		e.dest_reg = inst.dest_reg;
		case (inst.op)
			OP_ARITH:
			begin
				e.value = vec;
				e.mask = inst.mask;
			end
			OP_LD_BLOCK:
			begin
				e.value = line;
				e.mask = inst.mask;
			end
			OP_LD_GATHER:
			begin
				e.value = {NUM_LANES{ext}};
				e.mask = inst.mask & (16'd1 << inst.reg_lane);
			end
			default:
			begin
				e.value = {NUM_LANES{ext}};
				e.mask = '1;
			end
		endcase
		// Two instructions behind a rollback are squashed
		live = inst.valid && cycle - last_rb_cyc > 2;
		miss = inst.op != OP_ARITH && !m_valid[inst.result[9:6]];
		pc_load = inst.op inside {OP_LD_UBYTE, OP_LD_SBYTE, OP_LD_UHALF, OP_LD_SHALF,
			OP_LD_WORD} && !inst.is_vector && inst.has_writeback && inst.dest_reg == PC_REG;
		e.rb_valid = live && (miss || pc_load);
		e.rb_addr = miss ? inst.pc - 32'd4 : ext;
		e.wb_valid = live && inst.has_writeback && !e.rb_valid;
		if (e.rb_valid)
			last_rb_cyc = cycle;
		pend.push_back(e);
	endtask

	task automatic compare_outputs(input expect_t e);
		check_value("rollback valid", e.rb_valid, rollback.valid);
		if (e.rb_valid)
			check_value("rollback address", e.rb_addr, rollback.addr);
		check_value("write valid", e.wb_valid, wb.valid);
		if (e.wb_valid && wb.valid)
		begin
			check_value("write value", e.value, wb.value);
			check_value("write mask", e.mask, wb.mask);
			check_value("dest reg", e.dest_reg, wb.dest_reg);
			check_value("vector flag", e.is_vector, wb.is_vector);
		end
	endtask

	// Outputs settle after the rising edge, checked on the falling one
	always @(negedge clk)
	begin
		if (!reset_i)
		begin
			if (pend.size() > 0 && pend[0].cyc + 2 == cycle)
				compare_outputs(pend.pop_front());
			else
			begin
				check_value("idle write valid", 1'b0, wb.valid);
				check_value("idle rollback valid", 1'b0, rollback.valid);
			end
		end
		cycle = cycle + 1;
	end

	task automatic apb_access(input logic write, input logic [APB_ADDR_W-1:0] addr,
		input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_write(input logic [APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rd;
		logic err;
		apb_access(1'b1, addr, data, rd, err);
		check_value("write error flag", addr > INVAL_ADDR, err);
		if (addr < INVAL_ADDR)
		begin
			m_lines[addr[9:6]][addr[5:2] * LANE_W +: LANE_W] = data;
			m_valid[addr[9:6]] = 1'b1;
		end
		else if (addr == INVAL_ADDR)
			m_valid = '0;
	endtask

	task automatic apb_read(input logic [APB_ADDR_W-1:0] addr);
		logic [31:0] rd;
		logic err;
		apb_access(1'b0, addr, '0, rd, err);
		check_value("read error flag", addr >= INVAL_ADDR, err);
		if (addr < INVAL_ADDR)
			check_value("read data", m_lines[addr[9:6]][addr[5:2] * LANE_W +: LANE_W], rd);
	endtask

	task automatic begin_test(input string name);
		test_name = name;
		test_errors = errors;
	endtask

	task automatic end_test();
		drive_inst('0, '0);
		while (pend.size() > 0)
			@(negedge clk);
		tests_run++;
		if (errors != test_errors)
			tests_failed++;
		$display("Test %s done: %0d errors", test_name, errors - test_errors);
	endtask

	task automatic run_apb_test();
		logic [APB_ADDR_W-1:0] addr;
		begin_test("apb_fill_readback");
		for (int i = 0; i < FILL_WORDS; i++)
			apb_write(12'(i * 4), rand_word());
		// Beyond the invalidate register
		for (int i = 0; i < ERR_ACCESSES; i++)
		begin
			addr = 12'h404 + 12'(rand_word() & 32'h7FC);
			apb_write(addr, rand_word());
			apb_read(addr);
		end
		for (int i = 0; i < READ_CHECKS; i++)
			apb_read(12'(rand_word() & 32'h3FC));
		end_test();
	endtask

	task automatic run_load_tests();
		load_op_e op;
		begin_test("scalar_loads");
		for (int i = 0; i < SCALAR_LOADS; i++)
		begin
			op = load_op_e'(rand_word() % 5 + 1);
			drive_inst(make_inst(op, rand_word(), REG_IDX_W'(rand_word() % 31)), '0);
		end
		end_test();
		begin_test("block_gather_loads");
		for (int i = 0; i < VEC_LOADS; i++)
		begin
			op = rand_word() & 1 ? OP_LD_BLOCK : OP_LD_GATHER;
			drive_inst(make_inst(op, rand_word(), REG_IDX_W'(rand_word() % 31)), '0);
		end
		end_test();
		begin_test("arith_pass");
		for (int i = 0; i < ARITH_OPS; i++)
			drive_inst(make_inst(OP_ARITH, rand_word(), REG_IDX_W'(rand_word())), rand_vec());
		end_test();
	endtask

	task automatic run_rollback_tests();
		load_op_e op;
		logic [31:0] addr;
		logic [REG_IDX_W-1:0] dest;
		begin_test("miss_rollback");
		apb_write(INVAL_ADDR, '0);
		for (int i = 0; i < MISS_OPS; i++)
		begin
			// Refill two lines halfway through
			if (i == MISS_OPS / 2)
			begin
				drive_inst('0, '0);
				for (int w = 0; w < REFILL_WORDS; w++)
					apb_write(12'((w < NUM_LANES ? 2 : 5) * 64 + (w % NUM_LANES) * 4),
						rand_word());
			end
			op = load_op_e'(3'(rand_word()));
			drive_inst(make_inst(op, rand_word(), REG_IDX_W'(rand_word() % 31)), rand_vec());
		end
		end_test();
		begin_test("pc_load_rollback");
		for (int i = 0; i < PC_OPS; i++)
		begin
			addr = rand_word();
			addr[9:6] = addr[10] ? 4'd5 : 4'd2;
			dest = (i == 0 || rand_word() % 3 == 0) ? PC_REG : REG_IDX_W'(rand_word() % 31);
			op = load_op_e'(rand_word() % 5 + 1);
			drive_inst(make_inst(op, addr, dest), '0);
		end
		end_test();
	endtask

	initial
	begin
		seed = 95266;
		reset_i = 1'b1;
		issue = '0;
		result_vec = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_i <= 1'b0;
		run_apb_test();
		run_load_tests();
		run_rollback_tests();
		prop_failures = UUT.u_props.fail_count;
		$display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d, property fails: %0d",
			tests_run, tests_failed, checks, errors, prop_failures);
		if (errors == 0 && prop_failures == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* wb_pipe_props.sv */
// Pipeline output properties
`timescale 1ns/10ps
`default_nettype none

module wb_pipe_props
(
	input wire logic clk,
	input wire logic reset_i,
	input wire logic rb_valid_i,
	input wire logic wb_valid_i,
	input wire logic pready_i
);

	int fail_count = 0;

	// Rollback is a one-cycle pulse
	rb_pulse: assert property (@(posedge clk) disable iff (reset_i)
		rb_valid_i |=> !rb_valid_i)
		else
		begin
			fail_count++;
			$error("Rollback held high for two cycles");
		end

	// A rolled-back instruction never writes
	rb_no_write: assert property (@(posedge clk) disable iff (reset_i)
		rb_valid_i |-> !wb_valid_i)
		else
		begin
			fail_count++;
			$error("Register write in a rollback cycle");
		end

	// No wait states on the fill port
	apb_ready: assert property (@(posedge clk) pready_i)
		else
		begin
			fail_count++;
			$error("APB ready dropped");
		end

endmodule

`default_nettype wire

/* wb_pipe_top.sv */
// Memory access and writeback pipeline
`timescale 1ns/10ps
`default_nettype none

module wb_pipe_top
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset_i,
	input wire issue_t issue_i,
	input wire logic [VEC_W-1:0] result_vec_i,
	input wire logic psel_i,
	input wire logic penable_i,
	input wire logic pwrite_i,
	input wire logic [APB_ADDR_W-1:0] paddr_i,
	input wire logic [31:0] pwdata_i,
	output logic [31:0] prdata_o,
	output logic pready_o,
	output logic pslverr_o,
	output wb_t wb_o,
	output rollback_t rollback_o
);

	logic [LINE_IDX_W-1:0] rd_line;
	logic [VEC_W-1:0] rd_data;
	logic rd_valid;
	mem_rsp_t rsp;
	logic [VEC_W-1:0] rsp_vec;

	line_fill_apb u_line_fill (
		.clk(clk),
		.reset_i(reset_i),
		.psel_i(psel_i),
		.penable_i(penable_i),
		.pwrite_i(pwrite_i),
		.paddr_i(paddr_i),
		.pwdata_i(pwdata_i),
		.prdata_o(prdata_o),
		.pready_o(pready_o),
		.pslverr_o(pslverr_o),
		.rd_line_i(rd_line),
		.rd_data_o(rd_data),
		.rd_valid_o(rd_valid)
	);

	// Rollback pulse squashes the instruction entering the stage register
	mem_access_stage u_mem (
		.clk(clk),
		.reset_i(reset_i),
		.issue_i(issue_i),
		.result_vec_i(result_vec_i),
		.flush_i(rollback_o.valid),
		.rd_line_o(rd_line),
		.rd_data_i(rd_data),
		.rd_valid_i(rd_valid),
		.rsp_o(rsp),
		.rsp_vec_o(rsp_vec)
	);

	writeback_stage u_wb (
		.clk(clk),
		.reset_i(reset_i),
		.rsp_i(rsp),
		.rsp_vec_i(rsp_vec),
		.wb_o(wb_o),
		.rollback_o(rollback_o)
	);

endmodule

`default_nettype wire

/* writeback_stage.sv */
// Writeback stage
// Lane select, alignment, mask and rollback
`timescale 1ns/10ps
`default_nettype none

module writeback_stage
	import isa_pkg::*;
	import pipe_pkg::*;
(
	input wire logic clk,
	input wire logic reset_i,
	input wire mem_rsp_t rsp_i,
	input wire logic [VEC_W-1:0] rsp_vec_i,
	output wb_t wb_o,
	output rollback_t rollback_o
);

	logic in_valid;
	logic is_load;
	logic [LANE_IDX_W-1:0] lane_sel;
	logic [BYTE_OFS_W-1:0] byte_ofs;
	logic [LANE_W-1:0] lane_value;
	logic [BYTE_W-1:0] byte_aligned;
	logic [2*BYTE_W-1:0] half_aligned;
	logic [LANE_W-1:0] aligned_value;
	logic [VEC_W-1:0] value_nxt;
	logic [NUM_LANES-1:0] mask_nxt;
	logic rb_req;
	logic [31:0] rb_addr;
	logic miss;
	logic pc_load;

	logic wb_valid_q;
	logic wb_vector_q;
	logic [REG_IDX_W-1:0] wb_dest_q;
	logic [VEC_W-1:0] wb_value_q;
	logic [NUM_LANES-1:0] wb_mask_q;
	logic rb_valid_q;
	logic [31:0] rb_addr_q;

	// Younger instruction is dropped while a rollback is being signalled
	assign in_valid = rsp_i.inst.valid && !rb_valid_q;
	assign is_load = rsp_i.inst.op != OP_ARITH;

	assign lane_sel = addr_lane(rsp_i.inst.result);
	assign byte_ofs = addr_ofs(rsp_i.inst.result);
	assign lane_value = rsp_i.line[lane_sel * LANE_W +: LANE_W];

	// Big-endian lane, offset 0 is the top byte
	always_comb
	begin
		case (byte_ofs)
			2'd0: byte_aligned = lane_value[31:24];
			2'd1: byte_aligned = lane_value[23:16];
			2'd2: byte_aligned = lane_value[15:8];
			default: byte_aligned = lane_value[7:0];
		endcase
		half_aligned = byte_ofs[1] ? lane_value[15:0] : lane_value[31:16];
	end

	always_comb
	begin
		case (rsp_i.inst.op)
			OP_LD_UBYTE: aligned_value = {{(LANE_W - BYTE_W){1'b0}}, byte_aligned};
			OP_LD_SBYTE: aligned_value = {{(LANE_W - BYTE_W){byte_aligned[BYTE_W-1]}},
				byte_aligned};
			OP_LD_UHALF: aligned_value = {{(LANE_W - 2*BYTE_W){1'b0}}, half_aligned};
			OP_LD_SHALF: aligned_value = {{(LANE_W - 2*BYTE_W){half_aligned[2*BYTE_W-1]}},
				half_aligned};
			default: aligned_value = lane_value;
		endcase
	end

	// Result source and lane mask by operation
	always_comb
	begin
		case (rsp_i.inst.op)
			OP_ARITH:
			begin
				value_nxt = rsp_vec_i;
				mask_nxt = rsp_i.inst.mask;
			end
			OP_LD_BLOCK:
			begin
				value_nxt = rsp_i.line;
				mask_nxt = rsp_i.inst.mask;
			end
			OP_LD_GATHER:
			begin
				value_nxt = {NUM_LANES{aligned_value}};
				mask_nxt = rsp_i.inst.mask
					& ({{(NUM_LANES - 1){1'b0}}, 1'b1} << rsp_i.inst.reg_lane);
			end
			default:
			begin
				value_nxt = {NUM_LANES{aligned_value}};
				mask_nxt = '1;
			end
		endcase
	end

	// Miss wins over a load into the PC
	assign miss = in_valid && is_load && !rsp_i.hit;
	assign pc_load = in_valid && rsp_i.inst.has_writeback && !rsp_i.inst.is_vector
		&& rsp_i.inst.dest_reg == PC_REG && is_scalar_load(rsp_i.inst.op);
	assign rb_req = miss || pc_load;
	assign rb_addr = miss ? rsp_i.inst.pc - 32'd4 : aligned_value;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			wb_valid_q <= 1'b0;
			rb_valid_q <= 1'b0;
		end
		else
		begin
			wb_valid_q <= in_valid && rsp_i.inst.has_writeback && !rb_req;
			rb_valid_q <= rb_req;
		end
	end

	always_ff @(posedge clk)
	begin
		wb_vector_q <= rsp_i.inst.is_vector;
		wb_dest_q <= rsp_i.inst.dest_reg;
		wb_value_q <= value_nxt;
		wb_mask_q <= mask_nxt;
		rb_addr_q <= rb_addr;
	end

	assign wb_o = '{valid: wb_valid_q, is_vector: wb_vector_q, dest_reg: wb_dest_q,
		value: wb_value_q, mask: wb_mask_q};
	assign rollback_o = '{valid: rb_valid_q, addr: rb_addr_q};

endmodule

`default_nettype wire
